// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rename_unit_tb
FILELIST  ?= rename_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
EXE     := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(EXE)
	-./$(EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== free_list.sv ====
`timescale 1ns/1ps

// circular queue of free physical registers
module free_list (
    input  logic                  clk,
    input  logic                  reset,

    // allocation side
    input  logic                  pop,
    output rename_pkg::phys_reg_t head,
    output logic                  empty,

    // commit side, four-phase
    input  logic                  commit_req,
    output logic                  commit_ack,
    input  rename_pkg::phys_reg_t commit_phys_reg
);

    localparam int ptr_bits = $clog2(rename_pkg::free_depth);

    rename_pkg::phys_reg_t fifo_q [rename_pkg::free_depth];
    logic [ptr_bits-1:0]   head_ptr;
    logic [ptr_bits-1:0]   tail_ptr;
    rename_pkg::free_cnt_t free_cnt;
    logic                  push;

    assign head  = fifo_q[head_ptr];
    assign empty = (free_cnt == '0);

    // new commit seen on the link
    assign push = commit_req && !commit_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            // holds arch_regs .. phys_regs-1 in ascending order
            for (int i = 0; i < rename_pkg::free_depth; i++) begin
                fifo_q[i] <= rename_pkg::phys_reg_t'(rename_pkg::arch_regs + i);
            end
            head_ptr   <= '0;
            tail_ptr   <= '0;   // full, tail wrapped onto head
            free_cnt   <= rename_pkg::free_cnt_t'(rename_pkg::free_depth);
            commit_ack <= 1'b0;
        end else begin
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (push) begin
                fifo_q[tail_ptr] <= commit_phys_reg;
                tail_ptr         <= tail_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   free_cnt <= free_cnt + 1'b1;
                2'b01:   free_cnt <= free_cnt - 1'b1;
                default: free_cnt <= free_cnt;   // both or neither
            endcase

            if (push) begin
                commit_ack <= 1'b1;
            end else if (!commit_req) begin
                commit_ack <= 1'b0;
            end
        end
    end

endmodule

// ==== hs_stage.sv ====
`timescale 1ns/1ps

// one-entry buffer between two four-phase links
module hs_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,

    // upstream link, this stage is the receiver
    input  logic     up_req,
    output logic     up_ack,
    input  payload_t up_data,

    // downstream link, this stage is the sender
    output logic     dn_req,
    input  logic     dn_ack,
    output payload_t dn_data
);

    logic take;

    // both links back at idle before a new capture
    assign take = up_req && !up_ack && !dn_req && !dn_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            up_ack <= 1'b0;
            dn_req <= 1'b0;
        end else begin
            // upstream side
            if (take) begin
                up_ack <= 1'b1;
            end else if (!up_req) begin
                up_ack <= 1'b0;     // return to zero
            end

            // downstream side
            if (take) begin
                dn_req <= 1'b1;
            end else if (dn_ack) begin
                dn_req <= 1'b0;
            end
        end
    end

    // payload held until the next capture
    always_ff @(posedge clk) begin
        if (take) begin
            dn_data <= up_data;
        end
    end

endmodule

// ==== rename_core.sv ====
`timescale 1ns/1ps

// rename control: lookup, allocate, update, form result
module rename_core (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    in_req,
    output logic                    in_ack,
    input  rename_pkg::rename_req_t in_data,

    output logic                    out_req,
    input  logic                    out_ack,
    output rename_pkg::rename_rsp_t out_data,

    // alias table
    output rename_pkg::arch_reg_t   rd_arch1,
    output rename_pkg::arch_reg_t   rd_arch2,
    output rename_pkg::arch_reg_t   rd_arch3,
    input  rename_pkg::phys_reg_t   rd_phys1,
    input  rename_pkg::phys_reg_t   rd_phys2,
    input  rename_pkg::phys_reg_t   rd_phys3,
    output logic                    wr_en,
    output rename_pkg::arch_reg_t   wr_arch,
    output rename_pkg::phys_reg_t   wr_phys,

    // free list
    output logic                    pop,
    input  rename_pkg::phys_reg_t   head,
    input  logic                    empty
);

    logic accept;

    // stalls here while the free list is empty
    assign accept = in_req && !in_ack && !out_req && !out_ack && !empty;

    assign rd_arch1 = in_data.src1;
    assign rd_arch2 = in_data.src2;
    assign rd_arch3 = in_data.dest;    // old mapping of the destination

    assign wr_en   = accept;
    assign wr_arch = in_data.dest;
    assign wr_phys = head;
    assign pop     = accept;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            if (accept) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end

            if (accept) begin
                out_req <= 1'b1;
            end else if (out_ack) begin
                out_req <= 1'b0;
            end
        end
    end

    // sources sampled before the table write lands
    always_ff @(posedge clk) begin
        if (accept) begin
            out_data.phys_src1     <= rd_phys1;
            out_data.phys_src2     <= rd_phys2;
            out_data.phys_dest     <= head;
            out_data.phys_dest_old <= rd_phys3;
        end
    end

endmodule

// ==== rename_map_table.sv ====
`timescale 1ns/1ps

// register alias table, arch index -> current phys index
module rename_map_table (
    input  logic                  clk,
    input  logic                  reset,

    // lookup ports, combinational
    input  rename_pkg::arch_reg_t rd_arch1,
    input  rename_pkg::arch_reg_t rd_arch2,
    input  rename_pkg::arch_reg_t rd_arch3,
    output rename_pkg::phys_reg_t rd_phys1,
    output rename_pkg::phys_reg_t rd_phys2,
    output rename_pkg::phys_reg_t rd_phys3,

    // update port
    input  logic                  wr_en,
    input  rename_pkg::arch_reg_t wr_arch,
    input  rename_pkg::phys_reg_t wr_phys
);

    rename_pkg::phys_reg_t map_q [rename_pkg::arch_regs];

    // reads see the table before this cycle's write
    assign rd_phys1 = map_q[rd_arch1];
    assign rd_phys2 = map_q[rd_arch2];
    assign rd_phys3 = map_q[rd_arch3];

    always_ff @(posedge clk) begin
        if (reset) begin
            // identity map after reset
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (wr_en) begin
            map_q[wr_arch] <= wr_phys;
        end
    end

endmodule

// ==== rename_pkg.sv ====
package rename_pkg;

    // register file sizes
    localparam int arch_regs  = 32;
    localparam int phys_regs  = 64;
    localparam int free_depth = phys_regs - arch_regs;  // regs not mapped after reset

    localparam int arch_bits = $clog2(arch_regs);
    localparam int phys_bits = $clog2(phys_regs);
    localparam int cnt_bits  = $clog2(free_depth + 1);

    typedef logic [arch_bits-1:0] arch_reg_t;
    typedef logic [phys_bits-1:0] phys_reg_t;
    typedef logic [cnt_bits-1:0]  free_cnt_t;   // 0 .. free_depth

    // decoded instruction as seen by the rename stage
    typedef struct packed {
        arch_reg_t src1;
        arch_reg_t src2;
        arch_reg_t dest;
    } rename_req_t;

    // renamed instruction
    typedef struct packed {
        phys_reg_t phys_src1;
        phys_reg_t phys_src2;
        phys_reg_t phys_dest;
        phys_reg_t phys_dest_old;   // freed when this instruction commits
    } rename_rsp_t;

endpackage

// ==== rename_unit.f ====
rename_pkg.sv
hs_stage.sv
rename_map_table.sv
free_list.sv
rename_core.sv
rename_unit.sv
rename_unit_chk.sv
rename_unit_tb.sv

// ==== rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit (
    input  logic                  clk,
    input  logic                  reset,

    // rename requests from decode
    input  logic                  rename_req,
    output logic                  rename_ack,
    input  rename_pkg::arch_reg_t rename_src1,
    input  rename_pkg::arch_reg_t rename_src2,
    input  rename_pkg::arch_reg_t rename_dest,

    // renamed instructions
    output logic                  ren_req,
    input  logic                  ren_ack,
    output rename_pkg::phys_reg_t ren_phys_src1,
    output rename_pkg::phys_reg_t ren_phys_src2,
    output rename_pkg::phys_reg_t ren_phys_dest,
    output rename_pkg::phys_reg_t ren_phys_dest_old,

    // freed registers from the reorder buffer
    input  logic                  commit_req,
    output logic                  commit_ack,
    input  rename_pkg::phys_reg_t commit_phys_reg
);

    rename_pkg::rename_req_t req_data;
    rename_pkg::rename_req_t in_data;
    rename_pkg::rename_rsp_t out_data;
    rename_pkg::rename_rsp_t rsp_data;

    logic in_req, in_ack;
    logic out_req, out_ack;

    rename_pkg::arch_reg_t rd_arch1, rd_arch2, rd_arch3;
    rename_pkg::phys_reg_t rd_phys1, rd_phys2, rd_phys3;
    logic                  wr_en;
    rename_pkg::arch_reg_t wr_arch;
    rename_pkg::phys_reg_t wr_phys;
    logic                  pop, empty;
    rename_pkg::phys_reg_t head;

    assign req_data.src1 = rename_src1;
    assign req_data.src2 = rename_src2;
    assign req_data.dest = rename_dest;

    assign ren_phys_src1     = rsp_data.phys_src1;
    assign ren_phys_src2     = rsp_data.phys_src2;
    assign ren_phys_dest     = rsp_data.phys_dest;
    assign ren_phys_dest_old = rsp_data.phys_dest_old;

    hs_stage #(.payload_t(rename_pkg::rename_req_t)) intake_i (
        .clk(clk), .reset(reset),
        .up_req(rename_req), .up_ack(rename_ack), .up_data(req_data),
        .dn_req(in_req), .dn_ack(in_ack), .dn_data(in_data)
    );

    rename_core core_i (
        .clk(clk), .reset(reset),
        .in_req(in_req), .in_ack(in_ack), .in_data(in_data),
        .out_req(out_req), .out_ack(out_ack), .out_data(out_data),
        .rd_arch1(rd_arch1), .rd_arch2(rd_arch2), .rd_arch3(rd_arch3),
        .rd_phys1(rd_phys1), .rd_phys2(rd_phys2), .rd_phys3(rd_phys3),
        .wr_en(wr_en), .wr_arch(wr_arch), .wr_phys(wr_phys),
        .pop(pop), .head(head), .empty(empty)
    );

    rename_map_table map_table_i (
        .clk(clk), .reset(reset),
        .rd_arch1(rd_arch1), .rd_arch2(rd_arch2), .rd_arch3(rd_arch3),
        .rd_phys1(rd_phys1), .rd_phys2(rd_phys2), .rd_phys3(rd_phys3),
        .wr_en(wr_en), .wr_arch(wr_arch), .wr_phys(wr_phys)
    );

    free_list free_list_i (
        .clk(clk), .reset(reset),
        .pop(pop), .head(head), .empty(empty),
        .commit_req(commit_req), .commit_ack(commit_ack),
        .commit_phys_reg(commit_phys_reg)
    );

    hs_stage #(.payload_t(rename_pkg::rename_rsp_t)) issue_i (
        .clk(clk), .reset(reset),
        .up_req(out_req), .up_ack(out_ack), .up_data(out_data),
        .dn_req(ren_req), .dn_ack(ren_ack), .dn_data(rsp_data)
    );

endmodule

// ==== rename_unit_chk.sv ====
`timescale 1ns/1ps

// link protocol and free-list rules
module rename_unit_chk (
    input logic                  clk, reset,
    input logic                  rename_req, rename_ack,
    input rename_pkg::arch_reg_t rename_src1, rename_src2, rename_dest,
    input logic                  ren_req, ren_ack,
    input rename_pkg::phys_reg_t ren_phys_src1, ren_phys_src2,
    input rename_pkg::phys_reg_t ren_phys_dest, ren_phys_dest_old,
    input logic                  commit_req, commit_ack,
    input rename_pkg::phys_reg_t commit_phys_reg,
    input logic                  pop, empty,
    input rename_pkg::free_cnt_t free_cnt
);

    int fail_count = 0;

    rename_data_stable: assert property (@(posedge clk) disable iff (reset)
        (rename_req && !rename_ack) ##1 rename_req |-> $stable({rename_src1, rename_src2, rename_dest}))
        else begin fail_count++; $error("rename data changed before rename_ack"); end

    ren_data_stable: assert property (@(posedge clk) disable iff (reset)
        (ren_req && !ren_ack) ##1 ren_req
        |-> $stable({ren_phys_src1, ren_phys_src2, ren_phys_dest, ren_phys_dest_old}))
        else begin fail_count++; $error("result data changed before ren_ack"); end

    commit_data_stable: assert property (@(posedge clk) disable iff (reset)
        (commit_req && !commit_ack) ##1 commit_req |-> $stable(commit_phys_reg))
        else begin fail_count++; $error("commit data changed before commit_ack"); end

    // ack only answers a raised req
    rename_ack_order: assert property (@(posedge clk) disable iff (reset)
        $rose(rename_ack) |-> $past(rename_req))
        else begin fail_count++; $error("rename_ack rose without rename_req"); end

    ren_ack_order: assert property (@(posedge clk) disable iff (reset)
        $rose(ren_ack) |-> $past(ren_req))
        else begin fail_count++; $error("ren_ack rose without ren_req"); end

    commit_ack_order: assert property (@(posedge clk) disable iff (reset)
        $rose(commit_ack) |-> $past(commit_req))
        else begin fail_count++; $error("commit_ack rose without commit_req"); end

    no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty))
        else begin fail_count++; $error("free list popped while empty"); end

    no_push_full: assert property (@(posedge clk) disable iff (reset)
        (commit_req && !commit_ack && !pop)
        |-> free_cnt != rename_pkg::free_cnt_t'(rename_pkg::free_depth))
        else begin fail_count++; $error("commit accepted while free list full"); end

endmodule

bind rename_unit rename_unit_chk chk_i (.*, .free_cnt(free_list_i.free_cnt));

// ==== rename_unit_input.txt ====
// records of 8 hex fields: kind src1 src2 dest exp_src1 exp_src2 exp_dest exp_dest_old
// kind 01 rename, 02 commit (reg in field 2), 03 rename that stalls until exp_dest commits, 00 end
01 01 02 03 01 02 20 03   01 04 05 06 04 05 21 06
01 07 08 09 07 08 22 09   01 03 06 0a 20 21 23 0a
01 0b 09 0b 0b 22 24 0b   01 0b 0b 03 24 24 25 20
01 03 00 03 25 00 26 25   01 00 01 0c 00 01 27 0c
01 00 01 0d 00 01 28 0d   01 00 01 0e 00 01 29 0e
01 00 01 0f 00 01 2a 0f   01 00 01 10 00 01 2b 10
01 00 01 11 00 01 2c 11   01 00 01 12 00 01 2d 12
01 00 01 13 00 01 2e 13   01 00 01 14 00 01 2f 14
01 00 01 15 00 01 30 15   01 00 01 16 00 01 31 16
01 00 01 17 00 01 32 17   01 00 01 18 00 01 33 18
01 00 01 19 00 01 34 19   01 00 01 1a 00 01 35 1a
01 00 01 1b 00 01 36 1b   01 00 01 1c 00 01 37 1c
01 00 01 1d 00 01 38 1d   01 00 01 1e 00 01 39 1e
01 00 01 1f 00 01 3a 1f   01 0c 1f 0c 27 3a 3b 27
01 0d 1f 0d 28 3a 3c 28   01 0e 1f 0e 29 3a 3d 29
01 0f 1f 0f 2a 3a 3e 2a   01 10 1f 10 2b 3a 3f 2b
// free list now empty
03 0c 0d 02 3b 3c 03 02
02 0a 00 00 00 00 00 00   02 20 00 00 00 00 00 00   02 25 00 00 00 00 00 00
01 02 03 04 03 26 0a 04   01 04 04 02 0a 0a 20 03
01 1f 10 1f 3a 3f 25 3a
00 00 00 00 00 00 00 00

// ==== rename_unit_tb.sv ====
`timescale 1ns/1ps

module rename_unit_tb;

    localparam int words     = 512;   // 64 records of 8 fields
    localparam int timeout   = 200;   // cycles per wait
    localparam int quiet_win = 40;

    logic                  clk;
    logic                  reset;
    logic                  rename_req, rename_ack;
    rename_pkg::arch_reg_t rename_src1, rename_src2, rename_dest;
    logic                  ren_req, ren_ack;
    rename_pkg::phys_reg_t ren_phys_src1, ren_phys_src2;
    rename_pkg::phys_reg_t ren_phys_dest, ren_phys_dest_old;
    logic                  commit_req, commit_ack;
    rename_pkg::phys_reg_t commit_phys_reg;

    logic [7:0]  stim [words];
    logic [31:0] lcg_state;

    rename_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    function automatic rename_pkg::arch_reg_t arch_at(input int i);
        return rename_pkg::arch_reg_t'(stim[i]);
    endfunction

    function automatic rename_pkg::phys_reg_t phys_at(input int i);
        return rename_pkg::phys_reg_t'(stim[i]);
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_phys(input string name, input rename_pkg::phys_reg_t got,
                              input rename_pkg::phys_reg_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error at %0t: %s = %0b, expected %0b", $time, name, got, exp));
        end
    endtask

    // 0 rename_ack, 1 ren_req, 2 commit_ack
    task automatic wait_for(input int sel, input logic level, input string name);
        int   n;
        logic seen;
        n = 0;
        seen = ~level;
        while (seen !== level && n < timeout) begin
            @(posedge clk);
            case (sel)
                0:       seen = rename_ack;
                1:       seen = ren_req;
                default: seen = commit_ack;
            endcase
            n++;
        end
        if (seen !== level) begin
            stop_run($sformatf("timed out after %0d cycles waiting for %s to become %0b",
                               timeout, name, level));
        end
    endtask

    task automatic send_rename(input rename_pkg::arch_reg_t s1, input rename_pkg::arch_reg_t s2,
                               input rename_pkg::arch_reg_t d);
        @(posedge clk);
        rename_src1 <= s1;
        rename_src2 <= s2;
        rename_dest <= d;
        rename_req  <= 1'b1;
        wait_for(0, 1'b1, "rename_ack");
        rename_req <= 1'b0;
        wait_for(0, 1'b0, "rename_ack");
    endtask

    task automatic take_result(input rename_pkg::phys_reg_t e1, input rename_pkg::phys_reg_t e2,
                               input rename_pkg::phys_reg_t e3, input rename_pkg::phys_reg_t e4);
        int delay;
        wait_for(1, 1'b1, "ren_req");
        check_phys("ren_phys_src1", ren_phys_src1, e1);
        check_phys("ren_phys_src2", ren_phys_src2, e2);
        check_phys("ren_phys_dest", ren_phys_dest, e3);
        check_phys("ren_phys_dest_old", ren_phys_dest_old, e4);
        delay = next_rand() % 4;   // back-pressure on the result link
        repeat (delay) @(posedge clk);
        ren_ack <= 1'b1;
        wait_for(1, 1'b0, "ren_req");
        ren_ack <= 1'b0;
    endtask

    task automatic return_reg(input rename_pkg::phys_reg_t r);
        @(posedge clk);
        commit_phys_reg <= r;
        commit_req      <= 1'b1;
        wait_for(2, 1'b1, "commit_ack");
        commit_req <= 1'b0;
        wait_for(2, 1'b0, "commit_ack");
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_flag("ren_req", ren_req, 1'b0);
        end
    endtask

    // bound checker flagged a protocol or free-list violation
    always @(posedge clk) begin
        if (dut_i.chk_i.fail_count != 0) begin
            stop_run("an assertion in rename_unit_chk failed");
        end
    end

    initial begin
        int idx;
        int renames;
        bit running;
        reset           = 1'b1;
        rename_req      = 1'b0;
        rename_src1     = '0;
        rename_src2     = '0;
        rename_dest     = '0;
        ren_ack         = 1'b0;
        commit_req      = 1'b0;
        commit_phys_reg = '0;
        lcg_state       = 32'd12;
        $readmemh("rename_unit_input.txt", stim);
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // all links idle out of reset
        @(posedge clk);
        check_flag("rename_ack", rename_ack, 1'b0);
        check_flag("ren_req", ren_req, 1'b0);
        check_flag("commit_ack", commit_ack, 1'b0);

        idx = 0;
        renames = 0;
        running = 1'b1;
        while (running && idx < words) begin
            case (stim[idx])
                8'h01: begin
                    send_rename(arch_at(idx + 1), arch_at(idx + 2), arch_at(idx + 3));
                    take_result(phys_at(idx + 4), phys_at(idx + 5),
                                phys_at(idx + 6), phys_at(idx + 7));
                    renames++;
                end
                8'h02: return_reg(phys_at(idx + 1));
                8'h03: begin
                    // stalled on the empty free list until its dest comes back
                    send_rename(arch_at(idx + 1), arch_at(idx + 2), arch_at(idx + 3));
                    expect_quiet(quiet_win);
                    return_reg(phys_at(idx + 6));
                    take_result(phys_at(idx + 4), phys_at(idx + 5),
                                phys_at(idx + 6), phys_at(idx + 7));
                    renames++;
                end
                default: running = 1'b0;   // end marker
            endcase
            idx += 8;
        end
        if (renames == 0) begin
            stop_run("no rename records were read from rename_unit_input.txt");
        end
        expect_quiet(quiet_win);   // no stray results

        if (dut_i.chk_i.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "assertion failures in rename_unit_chk");
        end
    end

endmodule
